// ==== design/backend_config.svh ====
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// datapath sizes
`define BE_XLEN    32           // data word width
`define BE_NREG    32           // architectural registers, r0 reads zero
`define BE_NSTAGE  3            // ex, m1, m2
`define BE_IMM_W   16           // immediate width before sign extension

// operation encodings as delivered by the frontend decoder
`define BE_OP_W    3
`define BE_OP_ADD  3'd0
`define BE_OP_SUB  3'd1
`define BE_OP_AND  3'd2
`define BE_OP_OR   3'd3
`define BE_OP_XOR  3'd4
`define BE_OP_ADDI 3'd5         // rd = rs1 + sext(imm)
`define BE_OP_LW   3'd6         // rd = mem[rs1 + sext(imm)]
`define BE_OP_SW   3'd7         // mem[rs1 + sext(imm)] = rs2

`endif

// ==== design/backend_pkg.sv ====
`default_nettype none

`include "backend_config.svh"

package backend_pkg;

	typedef logic [`BE_XLEN-1:0]          word_t;
	typedef logic [$clog2(`BE_NREG)-1:0]  reg_addr_t;
	typedef logic [`BE_IMM_W-1:0]         imm_t;

	typedef enum logic [`BE_OP_W-1:0] {
		OP_ADD  = `BE_OP_ADD,
		OP_SUB  = `BE_OP_SUB,
		OP_AND  = `BE_OP_AND,
		OP_OR   = `BE_OP_OR,
		OP_XOR  = `BE_OP_XOR,
		OP_ADDI = `BE_OP_ADDI,
		OP_LW   = `BE_OP_LW,
		OP_SW   = `BE_OP_SW
	} op_e;

	// pipe stages, also the index into stall vectors and forwarding sources
	typedef enum logic [1:0] {EX = 2'd0, M1 = 2'd1, M2 = 2'd2} stage_e;

	// decoded instruction from the frontend
	typedef struct packed {
		op_e       op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		imm_t      imm;
		word_t     pc;
	} inst_t;

	typedef struct packed {
		logic   hit;    // operand comes from a pipe stage, not the regfile
		logic   pipe;
		stage_e stage;
	} fwd_sel_t;

	typedef struct packed {
		logic           valid;
		logic           older;      // first of its issue pair
		op_e            op;
		reg_addr_t      rd;
		imm_t           imm;
		fwd_sel_t [1:0] fwd_sel;    // [0] rs1, [1] rs2
	} ctrl_flow_t;

	typedef struct packed {
		word_t        pc;
		word_t [1:0]  rs_data;      // regfile read data
	} data_flow_t;

	// one stage of a pipe as seen by forwarding
	typedef struct packed {
		logic      valid;   // stage holds an instruction that writes rd
		logic      ready;   // result already known, low for a load before m2
		logic      older;
		reg_addr_t rd;
		word_t     result;
	} fwd_ent_t;

	typedef struct packed {
		fwd_ent_t [`BE_NSTAGE-1:0] ent;
	} fwd_src_t;

	// writeback trace entry
	typedef struct packed {
		logic      valid;
		logic      older;
		reg_addr_t rd;
		word_t     data;
		word_t     pc;
	} wb_t;

	typedef struct packed {
		logic  req;
		logic  we;
		word_t addr;
		word_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic  ack;
		word_t rdata;
	} bus_resp_t;

	function automatic logic be_is_mem(op_e op);
		return (op == OP_LW) || (op == OP_SW);
	endfunction

	// r0 writes are dropped everywhere
	function automatic logic be_writes_rd(op_e op, reg_addr_t rd);
		return (op != OP_SW) && (rd != '0);
	endfunction

endpackage

`default_nettype wire

// ==== design/mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_port (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   start_i,    // m1 holds a memory op
	input  logic                   we_i,
	input  backend_pkg::word_t     addr_i,
	input  backend_pkg::word_t     wdata_i,
	output logic                   done_o,     // one cycle, ack has dropped
	output backend_pkg::word_t     rdata_o,
	output backend_pkg::bus_req_t  bus_req_o,
	input  backend_pkg::bus_resp_t bus_resp_i
);
	import backend_pkg::*;

	typedef enum logic [1:0] {IDLE, REQ, RELEASE} state_e;

	state_e state_q, state_d;
	logic   we_q;
	word_t  addr_q, wdata_q, rdata_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:    if (start_i && !bus_resp_i.ack) state_d = REQ;  // previous ack must be gone
			REQ:     if (bus_resp_i.ack) state_d = RELEASE;
			RELEASE: if (!bus_resp_i.ack) state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) state_q <= IDLE;
		else state_q <= state_d;
	end

	// request fields frozen for the whole req phase
	always_ff @(posedge clk) begin
		if ((state_q == IDLE) && (state_d == REQ)) begin
			we_q    <= we_i;
			addr_q  <= addr_i;
			wdata_q <= wdata_i;
		end
		if ((state_q == REQ) && bus_resp_i.ack) rdata_q <= bus_resp_i.rdata; // valid with ack
	end

	always_comb begin
		bus_req_o.req   = (state_q == REQ);
		bus_req_o.we    = we_q;
		bus_req_o.addr  = addr_q;
		bus_req_o.wdata = wdata_q;
	end

	assign done_o  = (state_q == RELEASE) && !bus_resp_i.ack;
	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module reg_file #(
	parameter int REG_READ_PORT  = 4,
	parameter int REG_WRITE_PORT = 2
) (
	input  logic                                       clk,
	input  logic                                       rst_n_i,
	input  backend_pkg::reg_addr_t [REG_WRITE_PORT-1:0] w_ptr_i,
	input  backend_pkg::word_t     [REG_WRITE_PORT-1:0] w_data_i,
	input  logic                   [REG_WRITE_PORT-1:0] w_en_i,
	input  backend_pkg::reg_addr_t [REG_READ_PORT-1:0]  r_ptr_i,
	output backend_pkg::word_t     [REG_READ_PORT-1:0]  r_data_o
);
	import backend_pkg::*;

	word_t regs [`BE_NREG];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `BE_NREG; i++) regs[i] <= '0;
		end else begin
			for (int w = 0; w < REG_WRITE_PORT; w++) begin // higher port written last, wins
				if (w_en_i[w] && (w_ptr_i[w] != '0)) regs[w_ptr_i[w]] <= w_data_i[w];
			end
		end
	end

	// read with bypass of same-cycle writes
	always_comb begin
		for (int r = 0; r < REG_READ_PORT; r++) begin
			r_data_o[r] = regs[r_ptr_i[r]];
			for (int w = 0; w < REG_WRITE_PORT; w++) begin
				if (w_en_i[w] && (w_ptr_i[w] == r_ptr_i[r])) r_data_o[r] = w_data_i[w];
			end
			if (r_ptr_i[r] == '0) r_data_o[r] = '0; // r0 hardwired
		end
	end

endmodule

`default_nettype wire

// ==== design/issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module issue (
	input  backend_pkg::inst_t    [1:0]      inst_i,
	input  logic                  [1:0]      inst_valid_i,
	input  backend_pkg::fwd_src_t [1:0]      fwd_src_i,
	input  logic                             stall_i,      // ex or m1 frozen
	output logic                  [1:0]      issue_o,      // 00, 01 or 11
	output logic                             revert_o,     // slot 0 to pipe 1, slot 1 to pipe 0
	output backend_pkg::fwd_sel_t [1:0][1:0] fwd_sel_o     // [slot][operand]
);
	import backend_pkg::*;

	logic [1:0] is_mem;     // per slot
	logic [1:0] load_use;   // per slot
	logic       raw_dep;    // slot 1 reads slot 0 rd

	function automatic logic uses_rs2(op_e op);
		return !((op == OP_ADDI) || (op == OP_LW));
	endfunction

	// newest producer of rs, oldest stage scanned first so later hits override
	function automatic fwd_sel_t find_src(reg_addr_t rs, fwd_src_t [1:0] src);
		fwd_sel_t sel;
		logic     p;
		sel.hit   = 1'b0;
		sel.pipe  = 1'b0;
		sel.stage = EX;
		for (int s = `BE_NSTAGE - 1; s >= 0; s--) begin
			for (int k = 0; k < 2; k++) begin
				p = src[1].ent[s].older ^ (k == 1); // older pipe of the pair first
				if (src[p].ent[s].valid && (src[p].ent[s].rd == rs) && (rs != '0)) begin
					sel.hit   = 1'b1;
					sel.pipe  = p;
					sel.stage = stage_e'(s);
				end
			end
		end
		return sel;
	endfunction

	// producer found but its value is not there yet
	function automatic logic pending(fwd_sel_t sel, fwd_src_t [1:0] src);
		return sel.hit && !src[sel.pipe].ent[sel.stage].ready;
	endfunction

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			fwd_sel_o[i][0] = find_src(inst_i[i].rs1, fwd_src_i);
			fwd_sel_o[i][1] = find_src(inst_i[i].rs2, fwd_src_i);
			is_mem[i]       = be_is_mem(inst_i[i].op);
			load_use[i]     = pending(fwd_sel_o[i][0], fwd_src_i) ||
			                  (uses_rs2(inst_i[i].op) && pending(fwd_sel_o[i][1], fwd_src_i));
		end
	end

	// every op reads rs1
	assign raw_dep = be_writes_rd(inst_i[0].op, inst_i[0].rd) &&
	                 ((inst_i[1].rs1 == inst_i[0].rd) ||
	                  (uses_rs2(inst_i[1].op) && (inst_i[1].rs2 == inst_i[0].rd)));

	assign issue_o[0] = inst_valid_i[0] & ~stall_i & ~load_use[0];
	assign issue_o[1] = issue_o[0] & inst_valid_i[1] & ~raw_dep &
	                    ~(is_mem[0] & is_mem[1]) & ~load_use[1]; // in order, one mem per pair

	// memory ops only run in pipe 0
	assign revert_o = inst_valid_i[1] & is_mem[1] & ~is_mem[0];

endmodule

`default_nettype wire

// ==== design/backend_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module backend_pipeline #(
	parameter bit MAIN_PIPE = 1'b1      // pipe 0 owns the memory path
) (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  logic [`BE_NSTAGE-1:0]        stall_vec_i,   // indexed by stage_e
	input  logic                         issue_i,
	input  backend_pkg::ctrl_flow_t      ctrl_flow_i,
	input  backend_pkg::data_flow_t      data_flow_i,
	input  backend_pkg::fwd_src_t  [1:0] fwd_src_i,
	output logic [`BE_NSTAGE-1:0]        stall_req_o,
	output backend_pkg::fwd_src_t        fwd_src_o,
	output backend_pkg::wb_t             wb_o,
	output backend_pkg::bus_req_t        bus_req_o,
	input  backend_pkg::bus_resp_t       bus_resp_i
);
	import backend_pkg::*;

	typedef struct packed {
		logic      older;
		op_e       op;
		reg_addr_t rd;
		imm_t      imm;
		word_t     pc;
		word_t     a;       // rs1 value
		word_t     b;       // rs2 value, store data for sw
	} ex_t;

	typedef struct packed {
		logic      older;
		op_e       op;
		reg_addr_t rd;
		word_t     pc;
		word_t     result;  // alu result or memory address
		word_t     sdata;
	} mem_t;

	logic  ex_valid_q, m1_valid_q, m2_valid_q;
	ex_t   ex_d, ex_q;
	mem_t  m1_d, m1_q, m2_d, m2_q;
	word_t imm_ext;
	word_t alu_res;
	logic  mem_done;
	word_t mem_rdata;

	function automatic word_t pick(fwd_sel_t sel, word_t rf, fwd_src_t [1:0] src);
		return sel.hit ? src[sel.pipe].ent[sel.stage].result : rf;
	endfunction

	// operand select at the ex boundary
	always_comb begin
		ex_d.older = ctrl_flow_i.older;
		ex_d.op    = ctrl_flow_i.op;
		ex_d.rd    = ctrl_flow_i.rd;
		ex_d.imm   = ctrl_flow_i.imm;
		ex_d.pc    = data_flow_i.pc;
		ex_d.a     = pick(ctrl_flow_i.fwd_sel[0], data_flow_i.rs_data[0], fwd_src_i);
		ex_d.b     = pick(ctrl_flow_i.fwd_sel[1], data_flow_i.rs_data[1], fwd_src_i);
	end

	assign imm_ext = {{(`BE_XLEN - `BE_IMM_W){ex_q.imm[`BE_IMM_W-1]}}, ex_q.imm};

	always_comb begin
		case (ex_q.op)
			OP_ADD:  alu_res = ex_q.a + ex_q.b;
			OP_SUB:  alu_res = ex_q.a - ex_q.b;
			OP_AND:  alu_res = ex_q.a & ex_q.b;
			OP_OR:   alu_res = ex_q.a | ex_q.b;
			OP_XOR:  alu_res = ex_q.a ^ ex_q.b;
			default: alu_res = ex_q.a + imm_ext;   // addi, lw/sw address
		endcase
	end

	always_comb begin
		m1_d.older  = ex_q.older;
		m1_d.op     = ex_q.op;
		m1_d.rd     = ex_q.rd;
		m1_d.pc     = ex_q.pc;
		m1_d.result = alu_res;
		m1_d.sdata  = ex_q.b;
		m2_d        = m1_q;
		if (m1_q.op == OP_LW) m2_d.result = mem_rdata; // load data joins in m2
	end

	// a stage that is frozen while the next one moves hands on a bubble
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_valid_q <= 1'b0;
			m1_valid_q <= 1'b0;
			m2_valid_q <= 1'b0;
		end else begin
			if (!stall_vec_i[EX]) ex_valid_q <= issue_i & ctrl_flow_i.valid;
			if (!stall_vec_i[M1]) m1_valid_q <= ex_valid_q & ~stall_vec_i[EX];
			if (!stall_vec_i[M2]) m2_valid_q <= m1_valid_q & ~stall_vec_i[M1];
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_vec_i[EX] && issue_i) ex_q <= ex_d;
		if (!stall_vec_i[M1]) m1_q <= m1_d;
		if (!stall_vec_i[M2]) m2_q <= m2_d;
	end

	if (MAIN_PIPE) begin : g_mem
		mem_port u_mem_port (
			.clk        (clk),
			.rst_n_i    (rst_n_i),
			.start_i    (m1_valid_q & be_is_mem(m1_q.op)),
			.we_i       (m1_q.op == OP_SW),
			.addr_i     (m1_q.result),
			.wdata_i    (m1_q.sdata),
			.done_o     (mem_done),
			.rdata_o    (mem_rdata),
			.bus_req_o  (bus_req_o),
			.bus_resp_i (bus_resp_i)
		);
	end else begin : g_no_mem
		assign mem_done  = 1'b0;  // no memory ops reach this pipe
		assign mem_rdata = '0;
		assign bus_req_o = '0;
	end

	// m1 holds a memory op until the handshake is over
	always_comb begin
		stall_req_o     = '0;
		stall_req_o[M1] = MAIN_PIPE && m1_valid_q && be_is_mem(m1_q.op) && !mem_done;
	end

	always_comb begin
		fwd_src_o.ent[EX].valid  = ex_valid_q & be_writes_rd(ex_q.op, ex_q.rd);
		fwd_src_o.ent[EX].ready  = (ex_q.op != OP_LW);
		fwd_src_o.ent[EX].older  = ex_q.older;
		fwd_src_o.ent[EX].rd     = ex_q.rd;
		fwd_src_o.ent[EX].result = alu_res;
		fwd_src_o.ent[M1].valid  = m1_valid_q & be_writes_rd(m1_q.op, m1_q.rd);
		fwd_src_o.ent[M1].ready  = (m1_q.op != OP_LW);
		fwd_src_o.ent[M1].older  = m1_q.older;
		fwd_src_o.ent[M1].rd     = m1_q.rd;
		fwd_src_o.ent[M1].result = m1_q.result;
		fwd_src_o.ent[M2].valid  = m2_valid_q & be_writes_rd(m2_q.op, m2_q.rd);
		fwd_src_o.ent[M2].ready  = 1'b1;             // everything is known by m2
		fwd_src_o.ent[M2].older  = m2_q.older;
		fwd_src_o.ent[M2].rd     = m2_q.rd;
		fwd_src_o.ent[M2].result = m2_q.result;
	end

	// m2 is the writeback stage
	always_comb begin
		wb_o.valid = m2_valid_q & be_writes_rd(m2_q.op, m2_q.rd);
		wb_o.older = m2_q.older;
		wb_o.rd    = m2_q.rd;
		wb_o.data  = m2_q.result;
		wb_o.pc    = m2_q.pc;
	end

endmodule

`default_nettype wire

// ==== design/backend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module backend (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  backend_pkg::inst_t     [1:0] inst_i,
	input  logic                   [1:0] inst_valid_i,
	output logic                   [1:0] issue_num_o,      // 0, 1 or 2
	output logic                         backend_stall_o,
	output backend_pkg::wb_t       [1:0] wb_o,             // writeback trace per pipe
	output backend_pkg::bus_req_t        bus_req_o,
	input  backend_pkg::bus_resp_t       bus_resp_i
);
	import backend_pkg::*;

	logic [1:0][`BE_NSTAGE-1:0] stall_vec, stall_req;  // [pipe][stage]
	logic [1:0]                 issue;                 // per slot
	logic [1:0]                 pipe_issue;            // per pipe
	logic                       revert;
	fwd_sel_t   [1:0][1:0]      fwd_sel;
	fwd_src_t   [1:0]           fwd_src;
	ctrl_flow_t [1:0]           ctrl_flow;
	data_flow_t [1:0]           data_flow;
	reg_addr_t  [3:0]           reg_r_addr;            // pipe p uses 2p and 2p+1
	word_t      [3:0]           reg_r_data;
	reg_addr_t  [1:0]           reg_w_addr;
	word_t      [1:0]           reg_w_data;
	logic       [1:0]           reg_w_en;
	logic                       wb_swap;

	issue u_issue (
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.fwd_src_i    (fwd_src),
		.stall_i      (stall_vec[0][EX] | stall_vec[0][M1]),
		.issue_o      (issue),
		.revert_o     (revert),
		.fwd_sel_o    (fwd_sel)
	);

	assign issue_num_o = {issue[1], issue[0] & ~issue[1]};

	// slot to pipe routing, swapped by revert
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			logic slot;
			slot = revert ^ (p == 1);
			pipe_issue[p]           = issue[slot];
			ctrl_flow[p].valid      = inst_valid_i[slot];
			ctrl_flow[p].older      = ~slot;             // slot 0 comes first
			ctrl_flow[p].op         = inst_i[slot].op;
			ctrl_flow[p].rd         = inst_i[slot].rd;
			ctrl_flow[p].imm        = inst_i[slot].imm;
			ctrl_flow[p].fwd_sel    = fwd_sel[slot];
			reg_r_addr[2*p]         = inst_i[slot].rs1;
			reg_r_addr[2*p+1]       = inst_i[slot].rs2;
			data_flow[p].pc         = inst_i[slot].pc;
			data_flow[p].rs_data[0] = reg_r_data[2*p];
			data_flow[p].rs_data[1] = reg_r_data[2*p+1];
		end
	end

	// older write on port 0 so the younger one lands last
	assign wb_swap = wb_o[1].valid & wb_o[1].older;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			logic src;
			src = wb_swap ^ (w == 1);
			reg_w_en[w]   = wb_o[src].valid;
			reg_w_addr[w] = wb_o[src].rd;
			reg_w_data[w] = wb_o[src].data;
		end
	end

	reg_file #(
		.REG_READ_PORT  (4),
		.REG_WRITE_PORT (2)
	) u_reg_file (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.w_ptr_i  (reg_w_addr),
		.w_data_i (reg_w_data),
		.w_en_i   (reg_w_en),
		.r_ptr_i  (reg_r_addr),
		.r_data_o (reg_r_data)
	);

	backend_pipeline #(
		.MAIN_PIPE (1'b1)
	) pipeline_0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.stall_vec_i (stall_vec[0]),
		.issue_i     (pipe_issue[0]),
		.ctrl_flow_i (ctrl_flow[0]),
		.data_flow_i (data_flow[0]),
		.fwd_src_i   (fwd_src),
		.stall_req_o (stall_req[0]),
		.fwd_src_o   (fwd_src[0]),
		.wb_o        (wb_o[0]),
		.bus_req_o   (bus_req_o),
		.bus_resp_i  (bus_resp_i)
	);

	backend_pipeline #(
		.MAIN_PIPE (1'b0)
	) pipeline_1 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.stall_vec_i (stall_vec[1]),
		.issue_i     (pipe_issue[1]),
		.ctrl_flow_i (ctrl_flow[1]),
		.data_flow_i (data_flow[1]),
		.fwd_src_i   (fwd_src),
		.stall_req_o (stall_req[1]),
		.fwd_src_o   (fwd_src[1]),
		.wb_o        (wb_o[1]),
		.bus_req_o   (),                 // alu only pipe
		.bus_resp_i  ('0)
	);

	// a request freezes its own stage and every earlier one, in both pipes
	always_comb begin
		for (int lvl = 0; lvl < `BE_NSTAGE; lvl++) begin
			stall_vec[0][lvl] = 1'b0;
			for (int src = lvl; src < `BE_NSTAGE; src++) begin
				stall_vec[0][lvl] |= stall_req[0][src] | stall_req[1][src];
			end
			stall_vec[1][lvl] = stall_vec[0][lvl]; // pipes move in lockstep
		end
	end

	assign backend_stall_o = |stall_vec;

endmodule

`default_nettype wire

// ==== sim/tb_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module tb_backend;
	import backend_pkg::*;

	localparam int TIMEOUT = 2000;   // cycles for the whole program

	logic                clk;
	logic                rst_n_i;
	inst_t         [1:0] inst_i;
	logic          [1:0] inst_valid_i;
	logic          [1:0] issue_num_o;
	logic                backend_stall_o;
	wb_t           [1:0] wb_o;
	bus_req_t            bus_req_o;
	bus_resp_t           bus_resp_i;

	logic [43:0] words [0:127];     // whole input file, sections by address
	word_t       mem [16];          // memory slave contents
	int          n_mem, n_prog, n_exp, n_bus;
	int          head;              // first unissued instruction
	int          wb_idx, wb_prog, bus_idx, cyc, delay;
	int          test_err [5];
	int          checks;
	string       test_name [5];
	logic [31:0] lcg_state;
	bus_req_t    req_cap;           // request fields at req rise
	logic        req_prev;
	logic        seen_dep, seen_mem_pair, seen_dual, seen_revert;
	logic [1:0]  taken_q;           // issue count the dut acted on at the last rising edge

	backend dut (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.inst_i          (inst_i),
		.inst_valid_i    (inst_valid_i),
		.issue_num_o     (issue_num_o),
		.backend_stall_o (backend_stall_o),
		.wb_o            (wb_o),
		.bus_req_o       (bus_req_o),
		.bus_resp_i      (bus_resp_i)
	);

	always #2 clk = ~clk;

	// offer is held from the falling edge, so this is the count of the issue edge
	always @(posedge clk) begin
		taken_q <= issue_num_o;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic reads_rs2(op_e op);
		return (op != OP_ADDI) && (op != OP_LW);
	endfunction

	function automatic logic mem_op(op_e op);
		return (op == OP_LW) || (op == OP_SW);
	endfunction

	// program index of the next instruction that writes a register
	function automatic int next_writer(input int from);
		int          i;
		logic [43:0] w;
		i = from;
		while (i < n_prog) begin
			w = words[16+i];
			if ((op_e'(w[42:40]) != OP_SW) && (w[36:32] != 5'd0)) return i;
			i++;
		end
		return i;
	endfunction

	task automatic check_eq(input int t, input string name, input logic [31:0] got,
	                        input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			test_err[t]++;
		end
	endtask

	// pairing rules, looked at for the offer the dut just decided on
	task automatic check_pairing();
		logic dep, both_mem, w0;
		if ((inst_valid_i != 2'b11) || (taken_q == 2'd0)) return;
		w0 = (inst_i[0].op != OP_SW) && (inst_i[0].rd != 5'd0);
		dep = w0 && ((inst_i[1].rs1 == inst_i[0].rd) ||
		      (reads_rs2(inst_i[1].op) && (inst_i[1].rs2 == inst_i[0].rd)));
		both_mem = mem_op(inst_i[0].op) && mem_op(inst_i[1].op);
		if (dep || both_mem) begin
			check_eq(2, "issue_num_o", 32'(taken_q), 32'd1);
			if (dep) seen_dep = 1'b1;
			else seen_mem_pair = 1'b1;
		end else if (taken_q == 2'd2) begin
			if (!mem_op(inst_i[0].op) && !mem_op(inst_i[1].op)) seen_dual = 1'b1;
			if (mem_op(inst_i[1].op) && !mem_op(inst_i[0].op)) seen_revert = 1'b1;
		end
	endtask

	// writeback trace, older entry of a pair first
	task automatic collect_wb();
		int order [2];
		int n;
		n = 0;
		if (wb_o[0].valid && wb_o[1].valid) begin
			order[0] = wb_o[0].older ? 0 : 1;
			order[1] = 1 - order[0];
			n = 2;
		end else if (wb_o[0].valid) begin
			order[0] = 0;
			n = 1;
		end else if (wb_o[1].valid) begin
			order[0] = 1;
			n = 1;
		end
		for (int i = 0; i < n; i++) begin
			if (wb_idx >= n_exp) begin
				$display("unexpected writeback to r%0d after the expected sequence",
				         wb_o[order[i]].rd);
				test_err[1]++;
			end else begin
				wb_prog = next_writer(wb_prog);
				check_eq(1, "wb_o.rd", 32'(wb_o[order[i]].rd), 32'(words[48+wb_idx][36:32]));
				check_eq(1, "wb_o.data", wb_o[order[i]].data, words[48+wb_idx][31:0]);
				check_eq(1, "wb_o.pc", wb_o[order[i]].pc, 32'(wb_prog * 4));
				wb_prog++;
			end
			wb_idx++;
		end
	endtask

	// four-phase slave with random ack delay
	task automatic bus_slave();
		logic [31:0] r;
		logic [43:0] e;
		if (bus_req_o.req && !req_prev) begin
			if (bus_resp_i.ack) begin
				$display("request raised while ack was still high");
				test_err[4]++;
			end
			req_cap = bus_req_o;
			if (bus_idx < n_bus) begin
				e = words[80+bus_idx];
				check_eq(3, "bus_req_o.we", 32'(bus_req_o.we), 32'(e[40]));
				check_eq(3, "bus_req_o.addr", bus_req_o.addr, {24'h0, e[39:32]});
				if (e[40]) check_eq(3, "bus_req_o.wdata", bus_req_o.wdata, e[31:0]);
			end else begin
				$display("more bus transfers than listed in the input file");
				test_err[3]++;
			end
			bus_idx++;
			r = lcg_next();
			delay = int'(r[9:8]);   // 0 to 3 cycles
		end
		if (bus_req_o.req) begin
			check_eq(4, "bus_req_o.we", 32'(bus_req_o.we), 32'(req_cap.we));
			check_eq(4, "bus_req_o.addr", bus_req_o.addr, req_cap.addr);
			check_eq(4, "bus_req_o.wdata", bus_req_o.wdata, req_cap.wdata);
			check_eq(4, "backend_stall_o", 32'(backend_stall_o), 32'd1);
			if (!bus_resp_i.ack) begin
				if (delay == 0) begin
					bus_resp_i.ack = 1'b1;
					if (bus_req_o.we) mem[bus_req_o.addr[5:2]] = bus_req_o.wdata;
					else bus_resp_i.rdata = mem[bus_req_o.addr[5:2]];
				end else begin
					delay--;
				end
			end
		end else if (bus_resp_i.ack) begin
			bus_resp_i.ack   = 1'b0;    // master has let go
			bus_resp_i.rdata = '0;
		end
		req_prev = bus_req_o.req;
	endtask

	// frontend, next two unissued instructions, whole offer withheld now and then
	task automatic drive_offer();
		logic [31:0] r;
		logic [43:0] w;
		int          idx;
		r = lcg_next();
		for (int k = 0; k < 2; k++) begin
			idx = head + k;
			w = (idx < n_prog) ? words[16+idx] : 44'h0;
			inst_i[k].op    = op_e'(w[42:40]);
			inst_i[k].rd    = w[36:32];
			inst_i[k].rs1   = w[28:24];
			inst_i[k].rs2   = w[20:16];
			inst_i[k].imm   = w[15:0];
			inst_i[k].pc    = 32'(idx * 4);
			inst_valid_i[k] = (idx < n_prog) && (r[13:12] != 2'b00);
		end
	endtask

	initial begin
		int total_err, n_ok;
		test_name[0] = "reset state";
		test_name[1] = "writeback sequence";
		test_name[2] = "pairing rules";
		test_name[3] = "bus transfers";
		test_name[4] = "handshake protocol";
		for (int t = 0; t < 5; t++) test_err[t] = 0;
		clk = 1'b0;
		rst_n_i = 1'b0;
		inst_i = '0;
		inst_valid_i = 2'b00;
		bus_resp_i = '0;
		lcg_state = 32'he54e;
		checks = 0;
		head = 0;
		wb_idx = 0;
		wb_prog = 0;
		bus_idx = 0;
		delay = 0;
		req_prev = 1'b0;
		req_cap = '0;
		{seen_dep, seen_mem_pair, seen_dual, seen_revert} = 4'b0;
		$readmemh("sim/backend_input.txt", words);
		n_mem  = int'(words[0][7:0]);
		n_prog = int'(words[1][7:0]);
		n_exp  = int'(words[2][7:0]);
		n_bus  = int'(words[3][7:0]);
		for (int i = 0; i < 16; i++) mem[i] = 32'hc0de0000 | 32'(i * 4); // address pattern
		for (int i = 0; i < n_mem; i++) mem[i] = words[8+i][31:0];

		repeat (5) @(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		check_eq(0, "bus_req_o.req", 32'(bus_req_o.req), 32'd0);
		check_eq(0, "wb_o[0].valid", 32'(wb_o[0].valid), 32'd0);
		check_eq(0, "wb_o[1].valid", 32'(wb_o[1].valid), 32'd0);
		check_eq(0, "backend_stall_o", 32'(backend_stall_o), 32'd0);
		$display("test 1 %s: %s", test_name[0], (test_err[0] == 0) ? "ok" : "wrong");

		cyc = 0;
		while ((wb_idx < n_exp) && (cyc < TIMEOUT)) begin
			check_pairing();
			head += int'(taken_q);  // taken at the last rising edge
			collect_wb();
			bus_slave();
			drive_offer();
			@(negedge clk);
			cyc++;
		end

		if (wb_idx < n_exp) begin
			$display("timeout: only %0d of %0d writebacks arrived within %0d cycles",
			         wb_idx, n_exp, TIMEOUT);
			$display("*** FAILED ***");
			$finish;
		end else begin
			if (bus_idx != n_bus) begin
				$display("saw %0d bus transfers, the input file lists %0d", bus_idx, n_bus);
				test_err[3]++;
			end
			if (!(seen_dep && seen_mem_pair && seen_dual)) begin
				$display("not every pairing case was offered to the backend");
				test_err[2]++;
			end
			if (!seen_revert) begin
				$display("no memory instruction issued from slot 1");
				test_err[3]++;
			end
			total_err = 0;
			n_ok = 0;
			for (int t = 1; t < 5; t++) begin
				$display("test %0d %s: %s", t + 1, test_name[t],
				         (test_err[t] == 0) ? "ok" : "wrong");
			end
			for (int t = 0; t < 5; t++) begin
				total_err += test_err[t];
				if (test_err[t] == 0) n_ok++;
			end
			$display("tests %0d, ok %0d, wrong %0d, checks %0d, errors %0d",
			         5, n_ok, 5 - n_ok, checks, total_err);
			if (total_err == 0) begin
				$display("*** PASSED ***");
			end else begin
				$display("*** FAILED ***");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sim/backend_input.txt ====
// counts at @00: memory words, instructions, writebacks, bus transfers
// @08 memory from address 0, @10 program op_rd_rs1_rs2_imm, @30 wb rd_data, @50 bus we_addr_wdata
@00
3
12
10
5
@08
11111111
22222222
0000abcd
@10
5_01_00_00_0005
5_02_00_00_0007
0_03_01_02_0000
1_04_03_01_0000
4_05_04_02_0000
3_05_01_02_0000
2_06_05_03_0000
5_07_00_00_ffff
7_00_00_07_0008
6_08_00_00_0008
0_09_08_01_0000
5_0a_00_00_0020
5_0b_00_00_0010
6_0c_00_00_0004
0_0d_0c_0b_0000
7_00_00_0d_0000
6_0e_00_00_0000
4_0f_0e_09_0000
@30
01_00000005
02_00000007
03_0000000c
04_00000007
05_00000000
05_00000007
06_00000004
07_ffffffff
08_ffffffff
09_00000004
0a_00000020
0b_00000010
0c_22222222
0d_22222232
0e_22222232
0f_22222236
@50
1_08_ffffffff
0_08_00000000
0_04_00000000
1_00_22222232
0_00_00000000

// ==== backend.f ====
+incdir+design
design/backend_pkg.sv
design/mem_port.sv
design/reg_file.sv
design/issue.sv
design/backend_pipeline.sv
design/backend.sv
sim/tb_backend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_backend
FLIST     ?= backend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
